// File: hw/exu_pkg.sv
package exu_pkg;

	localparam int DATA_W = 32;
	localparam int BEAT_W = 64;
	localparam int BEAT_BYTES = 8;
	localparam int OFFSET_W = 3;
	localparam int REG_IDX_W = 5;
	localparam int WORD_STEP = 8;

	typedef logic [DATA_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [BEAT_BYTES-1:0] strb_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// add, then loads, then stores
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_LB  = 4'd1,
		OP_LBU = 4'd2,
		OP_LH  = 4'd3,
		OP_LHU = 4'd4,
		OP_LW  = 4'd5,
		OP_SB  = 4'd6,
		OP_SH  = 4'd7,
		OP_SW  = 4'd8
	} mem_op_t;

endpackage

// File: hw/mem_plan_if.sv
`timescale 1ns/1ps

interface mem_plan_if;
	import exu_pkg::*;

	addr_t beat_lo_addr;
	addr_t beat_hi_addr;
	logic two_beats;
	strb_t strb_lo;
	strb_t strb_hi;
	beat_t wdata_lo;
	beat_t wdata_hi;

	modport planner (
		output beat_lo_addr,
		output beat_hi_addr,
		output two_beats,
		output strb_lo,
		output strb_hi,
		output wdata_lo,
		output wdata_hi
	);

	modport engine (
		input beat_lo_addr,
		input beat_hi_addr,
		input two_beats,
		input strb_lo,
		input strb_hi,
		input wdata_lo,
		input wdata_hi
	);

endinterface

// File: hw/exu_stage_ctrl.sv
`timescale 1ns/1ps

module exu_stage_ctrl (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	input  exu_pkg::mem_op_t in_op,
	input  exu_pkg::addr_t in_base,
	input  exu_pkg::word_t in_offset,
	input  exu_pkg::word_t in_store_data,
	input  exu_pkg::reg_idx_t in_rd,
	input  logic load_done,
	input  logic store_done,
	input  exu_pkg::word_t load_word,
	output logic in_ready,
	output logic out_valid,
	output logic wb_en,
	output exu_pkg::reg_idx_t wb_rd,
	output exu_pkg::word_t wb_data,
	output logic load_start,
	output logic store_start,
	output exu_pkg::addr_t eff_addr,
	output exu_pkg::mem_op_t cur_op,
	output exu_pkg::word_t store_data
);
	import exu_pkg::*;

	logic stage_valid;
	addr_t base_r;
	word_t offset_r;
	reg_idx_t rd_r;
	logic is_load;
	logic is_store;
	logic ready_go;

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (in_ready) begin
			stage_valid <= in_valid;
		end
	end

	// operation fields, loaded on acceptance
	always_ff @(posedge clock) begin
		if (in_valid && in_ready) begin
			cur_op <= in_op;
			base_r <= in_base;
			offset_r <= in_offset;
			store_data <= in_store_data;
			rd_r <= in_rd;
		end
	end

	assign is_load = cur_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	assign is_store = cur_op inside {OP_SB, OP_SH, OP_SW};

	// add finishes at once, memory ops wait for their engine
	always_comb begin
		if (is_load)
			ready_go = load_done;
		else if (is_store)
			ready_go = store_done;
		else
			ready_go = 1'b1;
	end

	assign eff_addr = base_r + offset_r;

	assign in_ready = !stage_valid || ready_go;
	assign out_valid = stage_valid && ready_go;
	assign load_start = stage_valid && is_load;
	assign store_start = stage_valid && is_store;

	assign wb_en = out_valid && !is_store;
	assign wb_rd = rd_r;
	assign wb_data = is_load ? load_word : eff_addr;

endmodule

// File: hw/access_planner.sv
`timescale 1ns/1ps

module access_planner (
	input  exu_pkg::addr_t eff_addr,
	input  exu_pkg::mem_op_t cur_op,
	input  exu_pkg::word_t store_data,
	mem_plan_if.planner plan
);
	import exu_pkg::*;

	logic [OFFSET_W-1:0] offset;
	logic [OFFSET_W:0] end_pos;
	logic [2:0] size_bytes;
	logic [3:0] lane_mask;
	word_t data_mask;
	addr_t lo_addr;
	logic [2*BEAT_BYTES-1:0] strb_pair;
	logic [2*BEAT_W-1:0] data_pair;

	assign offset = eff_addr[OFFSET_W-1:0];

	always_comb begin
		case (cur_op)
			OP_LB, OP_LBU, OP_SB: begin
				size_bytes = 3'd1;
				lane_mask = 4'b0001;
			end
			OP_LH, OP_LHU, OP_SH: begin
				size_bytes = 3'd2;
				lane_mask = 4'b0011;
			end
			OP_LW, OP_SW: begin
				size_bytes = 3'd4;
				lane_mask = 4'b1111;
			end
			default: begin
				size_bytes = 3'd0;
				lane_mask = 4'b0000;
			end
		endcase
	end

	// one strobe bit widened to a byte of data mask
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			data_mask[i*8 +: 8] = {8{lane_mask[i]}};
		end
	end

	// crosses when the last byte lands past the beat
	assign end_pos = {1'b0, offset} + size_bytes;
	assign plan.two_beats = end_pos > BEAT_BYTES;

	assign lo_addr = {eff_addr[DATA_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
	assign plan.beat_lo_addr = lo_addr;
	assign plan.beat_hi_addr = lo_addr + addr_t'(WORD_STEP);

	// lanes across both beats, low beat in the lower half
	assign strb_pair = {{BEAT_BYTES{1'b0}}, 4'b0000, lane_mask} << offset;
	assign data_pair = {{BEAT_W{1'b0}}, {DATA_W{1'b0}}, store_data & data_mask}
		<< {offset, 3'b000};

	assign plan.strb_lo = strb_pair[BEAT_BYTES-1:0];
	assign plan.strb_hi = strb_pair[2*BEAT_BYTES-1:BEAT_BYTES];
	assign plan.wdata_lo = data_pair[BEAT_W-1:0];
	assign plan.wdata_hi = data_pair[2*BEAT_W-1:BEAT_W];

endmodule

// File: hw/load_engine.sv
`timescale 1ns/1ps

module load_engine (
	input  logic clock,
	input  logic reset,
	input  logic load_start,
	input  logic ar_ready,
	input  logic r_valid,
	input  exu_pkg::beat_t r_data,
	mem_plan_if.engine plan,
	output logic ar_valid,
	output exu_pkg::addr_t ar_addr,
	output logic r_ready,
	output logic load_done,
	output exu_pkg::beat_t first_beat,
	output exu_pkg::beat_t last_beat
);

	localparam logic [1:0] L_IDLE = 2'd0;
	localparam logic [1:0] L_ADDR = 2'd1;
	localparam logic [1:0] L_DATA = 2'd2;
	localparam logic [1:0] L_DONE = 2'd3;

	logic [1:0] state;
	logic [1:0] state_next;
	logic second;
	logic r_fire;

	assign r_fire = (state == L_DATA) && r_valid;

	always_comb begin
		state_next = state;
		case (state)
			L_IDLE:
				if (load_start)
					state_next = L_ADDR;
			L_ADDR:
				if (ar_ready)
					state_next = L_DATA;
			L_DATA:
				if (r_valid)
					state_next = (plan.two_beats && !second) ? L_ADDR : L_DONE;
			default:
				state_next = L_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= L_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			if (r_fire && plan.two_beats && !second)
				second <= 1'b1;
			else if (state == L_DONE)
				second <= 1'b0;
		end
	end

	// first beat held while the upper one is fetched
	always_ff @(posedge clock) begin
		if (r_fire && !second)
			first_beat <= r_data;
		if (r_fire)
			last_beat <= r_data;
	end

	assign ar_valid = state == L_ADDR;
	assign ar_addr = second ? plan.beat_hi_addr : plan.beat_lo_addr;
	assign r_ready = state == L_DATA;
	assign load_done = state == L_DONE;

endmodule

// File: hw/store_engine.sv
`timescale 1ns/1ps

module store_engine (
	input  logic clock,
	input  logic reset,
	input  logic store_start,
	input  logic aw_ready,
	input  logic w_ready,
	input  logic b_valid,
	mem_plan_if.engine plan,
	output logic aw_valid,
	output exu_pkg::addr_t aw_addr,
	output logic w_valid,
	output exu_pkg::beat_t w_data,
	output exu_pkg::strb_t w_strb,
	output logic b_ready,
	output logic store_done
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ADDR = 3'd1;
	localparam logic [2:0] S_DATA = 3'd2;
	localparam logic [2:0] S_RESP = 3'd3;
	localparam logic [2:0] S_DONE = 3'd4;

	logic [2:0] state;
	logic [2:0] state_next;
	logic second;
	logic b_fire;

	assign b_fire = (state == S_RESP) && b_valid;

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:
				if (store_start)
					state_next = S_ADDR;
			S_ADDR:
				if (aw_ready)
					state_next = S_DATA;
			S_DATA:
				if (w_ready)
					state_next = S_RESP;
			S_RESP:
				if (b_valid)
					state_next = (plan.two_beats && !second) ? S_ADDR : S_DONE;
			S_DONE:
				state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= S_IDLE;
			second <= 1'b0;
		end else begin
			state <= state_next;
			// upper beat follows the first write response
			if (b_fire && plan.two_beats && !second)
				second <= 1'b1;
			else if (state == S_DONE)
				second <= 1'b0;
		end
	end

	assign aw_valid = state == S_ADDR;
	assign w_valid = state == S_DATA;
	assign b_ready = state == S_RESP;
	assign store_done = state == S_DONE;

	assign aw_addr = second ? plan.beat_hi_addr : plan.beat_lo_addr;
	assign w_strb = second ? plan.strb_hi : plan.strb_lo;
	assign w_data = second ? plan.wdata_hi : plan.wdata_lo;

endmodule

// File: hw/load_aligner.sv
`timescale 1ns/1ps

module load_aligner (
	input  exu_pkg::mem_op_t cur_op,
	input  exu_pkg::addr_t eff_addr,
	input  exu_pkg::beat_t first_beat,
	input  exu_pkg::beat_t last_beat,
	mem_plan_if.engine plan,
	output exu_pkg::word_t load_word
);
	import exu_pkg::*;

	beat_t upper_beat;
	logic [2*BEAT_W-1:0] window;
	word_t raw;

	// little endian, upper beat continues past byte 7
	assign upper_beat = plan.two_beats ? last_beat : '0;
	assign window = {upper_beat, first_beat} >> {eff_addr[OFFSET_W-1:0], 3'b000};
	assign raw = window[DATA_W-1:0];

	always_comb begin
		case (cur_op)
			OP_LB:
				load_word = {{24{raw[7]}}, raw[7:0]};
			OP_LBU:
				load_word = {24'd0, raw[7:0]};
			OP_LH:
				load_word = {{16{raw[15]}}, raw[15:0]};
			OP_LHU:
				load_word = {16'd0, raw[15:0]};
			OP_LW:
				load_word = raw;
			default:
				load_word = '0;
		endcase
	end

endmodule

// File: hw/exu_lsu_top.sv
`timescale 1ns/1ps

module exu_lsu_top (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	output logic in_ready,
	input  exu_pkg::mem_op_t in_op,
	input  exu_pkg::addr_t in_base,
	input  exu_pkg::word_t in_offset,
	input  exu_pkg::word_t in_store_data,
	input  exu_pkg::reg_idx_t in_rd,
	output logic out_valid,
	output logic wb_en,
	output exu_pkg::reg_idx_t wb_rd,
	output exu_pkg::word_t wb_data,
	output logic ar_valid,
	input  logic ar_ready,
	output exu_pkg::addr_t ar_addr,
	input  logic r_valid,
	output logic r_ready,
	input  exu_pkg::beat_t r_data,
	output logic aw_valid,
	input  logic aw_ready,
	output exu_pkg::addr_t aw_addr,
	output logic w_valid,
	input  logic w_ready,
	output exu_pkg::beat_t w_data,
	output exu_pkg::strb_t w_strb,
	input  logic b_valid,
	output logic b_ready
);
	import exu_pkg::*;

	logic load_start;
	logic store_start;
	logic load_done;
	logic store_done;
	addr_t eff_addr;
	mem_op_t cur_op;
	word_t store_data;
	word_t load_word;
	beat_t first_beat;
	beat_t last_beat;

	mem_plan_if plan_bus ();

	exu_stage_ctrl stage0 (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_base(in_base),
		.in_offset(in_offset),
		.in_store_data(in_store_data),
		.in_rd(in_rd),
		.load_done(load_done),
		.store_done(store_done),
		.load_word(load_word),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.load_start(load_start),
		.store_start(store_start),
		.eff_addr(eff_addr),
		.cur_op(cur_op),
		.store_data(store_data)
	);

	access_planner planner0 (
		.eff_addr(eff_addr),
		.cur_op(cur_op),
		.store_data(store_data),
		.plan(plan_bus.planner)
	);

	load_engine load0 (
		.clock(clock),
		.reset(reset),
		.load_start(load_start),
		.ar_ready(ar_ready),
		.r_valid(r_valid),
		.r_data(r_data),
		.plan(plan_bus.engine),
		.ar_valid(ar_valid),
		.ar_addr(ar_addr),
		.r_ready(r_ready),
		.load_done(load_done),
		.first_beat(first_beat),
		.last_beat(last_beat)
	);

	store_engine store0 (
		.clock(clock),
		.reset(reset),
		.store_start(store_start),
		.aw_ready(aw_ready),
		.w_ready(w_ready),
		.b_valid(b_valid),
		.plan(plan_bus.engine),
		.aw_valid(aw_valid),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_data(w_data),
		.w_strb(w_strb),
		.b_ready(b_ready),
		.store_done(store_done)
	);

	load_aligner aligner0 (
		.cur_op(cur_op),
		.eff_addr(eff_addr),
		.first_beat(first_beat),
		.last_beat(last_beat),
		.plan(plan_bus.engine),
		.load_word(load_word)
	);

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import exu_pkg::*;

	localparam logic [31:0] SEED = 32'h4a88d51c;
	localparam int MEM_BEATS = 64;
	localparam int MEM_BYTES = MEM_BEATS * BEAT_BYTES;
	localparam int RANDOM_OPS = 400;

	logic clock = 1'b0;
	logic reset = 1'b1;

	// stimulus side
	logic in_valid = 1'b0;
	mem_op_t in_op = OP_ADD;
	addr_t in_base = '0;
	word_t in_offset = '0;
	word_t in_store_data = '0;
	reg_idx_t in_rd = '0;

	// memory model side
	logic ar_ready = 1'b0;
	logic r_valid = 1'b0;
	beat_t r_data = '0;
	logic aw_ready = 1'b0;
	logic w_ready = 1'b0;
	logic b_valid = 1'b0;
	logic rd_pending = 1'b0;
	logic b_pending = 1'b0;
	addr_t rd_addr = '0;
	addr_t wr_addr = '0;
	beat_t mem [0:MEM_BEATS-1];
	logic [31:0] mem_rng = SEED ^ 32'h9e3779b9;

	// DUT outputs
	logic in_ready;
	logic out_valid;
	logic wb_en;
	reg_idx_t wb_rd;
	word_t wb_data;
	logic ar_valid;
	addr_t ar_addr;
	logic r_ready;
	logic aw_valid;
	addr_t aw_addr;
	logic w_valid;
	beat_t w_data;
	strb_t w_strb;
	logic b_ready;

	// program and reference state
	mem_op_t prog_op_q[$];
	addr_t prog_base_q[$];
	word_t prog_off_q[$];
	word_t prog_data_q[$];
	reg_idx_t prog_rd_q[$];
	mem_op_t exp_op_q[$];
	word_t exp_data_q[$];
	reg_idx_t exp_rd_q[$];
	time exp_time_q[$];
	addr_t exp_ar_q[$];
	addr_t exp_aw_q[$];
	strb_t exp_strb_q[$];
	logic [7:0] shadow [0:MEM_BYTES-1];
	logic [31:0] stim_rng = SEED;
	int num_ops = 0;
	int next_op = 0;
	int done_count = 0;
	logic busy_mem = 1'b0;

	exu_lsu_top dut0 (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_op(in_op),
		.in_base(in_base),
		.in_offset(in_offset),
		.in_store_data(in_store_data),
		.in_rd(in_rd),
		.out_valid(out_valid),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.ar_valid(ar_valid),
		.ar_ready(ar_ready),
		.ar_addr(ar_addr),
		.r_valid(r_valid),
		.r_ready(r_ready),
		.r_data(r_data),
		.aw_valid(aw_valid),
		.aw_ready(aw_ready),
		.aw_addr(aw_addr),
		.w_valid(w_valid),
		.w_ready(w_ready),
		.w_data(w_data),
		.w_strb(w_strb),
		.b_valid(b_valid),
		.b_ready(b_ready)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		stim_rng = xorshift(stim_rng);
		return stim_rng;
	endfunction

	// initial memory contents as a function of the full byte address
	function automatic logic [7:0] fill_byte(input int a);
		logic [15:0] t;
		t = 16'(a * 157 + (a >> 4) * 51 + 90);
		return t[7:0] ^ t[15:8];
	endfunction

	function automatic int op_size(input mem_op_t op);
		case (op)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			OP_LW, OP_SW: return 4;
			default: return 0;
		endcase
	endfunction

	function automatic logic is_store(input mem_op_t op);
		return op == OP_SB || op == OP_SH || op == OP_SW;
	endfunction

	function automatic mem_op_t load_op(input int k);
		case (k)
			0: return OP_LB;
			1: return OP_LBU;
			2: return OP_LH;
			3: return OP_LHU;
			default: return OP_LW;
		endcase
	endfunction

	function automatic mem_op_t store_op(input int k);
		case (k)
			0: return OP_SB;
			1: return OP_SH;
			default: return OP_SW;
		endcase
	endfunction

	// expected writeback from the shadow bytes plus the lanes per beat
	function automatic word_t expected_result(input mem_op_t op, input addr_t base,
			input word_t offset, output strb_t strb_lo, output strb_t strb_hi);
		addr_t addr;
		addr_t byte_addr;
		word_t raw;
		addr = base + offset;
		raw = '0;
		strb_lo = '0;
		strb_hi = '0;
		for (int b = 0; b < op_size(op); b++) begin
			byte_addr = addr + addr_t'(b);
			raw[b*8 +: 8] = shadow[byte_addr[8:0]];
			if (byte_addr[31:3] == addr[31:3])
				strb_lo[byte_addr[2:0]] = 1'b1;
			else
				strb_hi[byte_addr[2:0]] = 1'b1;
		end
		case (op)
			OP_ADD: return addr;
			OP_LB: return {{24{raw[7]}}, raw[7:0]};
			OP_LBU: return {24'd0, raw[7:0]};
			OP_LH: return {{16{raw[15]}}, raw[15:0]};
			OP_LHU: return {16'd0, raw[15:0]};
			OP_LW: return raw;
			default: return '0;
		endcase
	endfunction

	task automatic apply_store(input addr_t addr, input word_t data, input int size);
		addr_t byte_addr;
		for (int b = 0; b < size; b++) begin
			byte_addr = addr + addr_t'(b);
			shadow[byte_addr[8:0]] = data[b*8 +: 8];
		end
	endtask

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_strb(input string name, input strb_t got, input strb_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_failure($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	// random split of the address into base and a signed 12-bit offset
	task automatic add_op(input mem_op_t op, input addr_t addr, input word_t data);
		logic [31:0] r;
		word_t off;
		r = next_rand();
		off = {{20{r[11]}}, r[11:0]};
		prog_op_q.push_back(op);
		prog_base_q.push_back(addr - off);
		prog_off_q.push_back(off);
		prog_data_q.push_back(data);
		prog_rd_q.push_back(r[31:27]);
	endtask

	task automatic build_program();
		addr_t lo;
		logic [3:0] code;
		for (int a = 0; a < MEM_BYTES; a++)
			shadow[a] = fill_byte(a);
		for (int i = 0; i < 8; i++)
			add_op(OP_ADD, next_rand(), 32'd0);
		// aligned loads of every kind
		for (int k = 0; k < 5; k++)
			for (int j = 0; j < 4; j++)
				add_op(load_op(k), next_rand() & ~32'h3, 32'd0);
		// each store size at each offset read back with its neighbors
		for (int s = 0; s < 3; s++) begin
			for (int o = 0; o < 8; o++) begin
				lo = addr_t'(16 * (s * 8 + o));
				add_op(store_op(s), lo + addr_t'(o), next_rand());
				add_op(load_op(2 * s), lo + addr_t'(o), 32'd0);
				add_op(OP_LW, lo, 32'd0);
				add_op(OP_LW, lo + 32'd4, 32'd0);
				add_op(OP_LW, lo + 32'd8, 32'd0);
			end
		end
		// loads across a beat boundary
		add_op(OP_LW, 32'h1fd, 32'd0);
		add_op(OP_LW, 32'h1fe, 32'd0);
		add_op(OP_LW, 32'h1ff, 32'd0);
		add_op(OP_LH, 32'h0f7, 32'd0);
		add_op(OP_LHU, 32'h0f7, 32'd0);
		for (int i = 0; i < RANDOM_OPS; i++) begin
			code = 4'(next_rand() % 32'd9);
			add_op(mem_op_t'(code), next_rand(), next_rand());
		end
		num_ops = prog_op_q.size();
	endtask

	task automatic record_accept(input int i);
		mem_op_t op;
		addr_t addr;
		addr_t lo;
		strb_t s_lo;
		strb_t s_hi;
		word_t res;
		op = prog_op_q[i];
		addr = prog_base_q[i] + prog_off_q[i];
		lo = {addr[31:3], 3'b000};
		res = expected_result(op, prog_base_q[i], prog_off_q[i], s_lo, s_hi);
		exp_op_q.push_back(op);
		exp_data_q.push_back(res);
		exp_rd_q.push_back(prog_rd_q[i]);
		exp_time_q.push_back($time);
		if (is_store(op)) begin
			exp_aw_q.push_back(lo);
			exp_strb_q.push_back(s_lo);
			if (s_hi != '0) begin
				exp_aw_q.push_back(lo + 32'd8);
				exp_strb_q.push_back(s_hi);
			end
			apply_store(addr, prog_data_q[i], op_size(op));
		end else if (op != OP_ADD) begin
			exp_ar_q.push_back(lo);
			if (s_hi != '0)
				exp_ar_q.push_back(lo + 32'd8);
		end
	endtask

	task automatic compare_completion();
		mem_op_t op;
		word_t data;
		reg_idx_t rd;
		time t_acc;
		if (exp_op_q.size() == 0) begin
			stop_with_failure("out_valid pulsed with no operation outstanding");
		end else begin
			op = exp_op_q.pop_front();
			data = exp_data_q.pop_front();
			rd = exp_rd_q.pop_front();
			t_acc = exp_time_q.pop_front();
			check_flag("wb_en", wb_en, !is_store(op));
			if (!is_store(op)) begin
				check_reg("wb_rd", wb_rd, rd);
				check_word("wb_data", wb_data, data);
			end
			if (op == OP_ADD && $time - t_acc != 5)
				stop_with_failure("ADD result did not arrive one cycle after acceptance");
			done_count++;
		end
	endtask

	// stimulus offering one operation per cycle with occasional gaps
	initial begin
		build_program();
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		while (next_op < num_ops) begin
			@(posedge clock);
			if (in_valid && in_ready) begin
				record_accept(next_op);
				busy_mem <= prog_op_q[next_op] != OP_ADD;
				next_op++;
			end else if (in_ready) begin
				busy_mem <= 1'b0;
			end
			if (!in_valid || in_ready) begin
				if (next_op < num_ops && next_rand() % 32'd8 != 0) begin
					in_valid <= 1'b1;
					in_op <= prog_op_q[next_op];
					in_base <= prog_base_q[next_op];
					in_offset <= prog_off_q[next_op];
					in_store_data <= prog_data_q[next_op];
					in_rd <= prog_rd_q[next_op];
				end else begin
					in_valid <= 1'b0;
				end
			end
		end
		// the last operation drains with nothing behind it
		while (done_count < num_ops) begin
			@(posedge clock);
			if (in_ready)
				busy_mem <= 1'b0;
		end
		repeat (4) @(posedge clock);
		if (exp_ar_q.size() != 0 || exp_aw_q.size() != 0 || exp_strb_q.size() != 0) begin
			stop_with_failure("memory beats were expected but never issued");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

	// results sampled mid-cycle where outputs are settled
	always @(negedge clock) begin
		if (!reset) begin
			if (busy_mem && in_ready && !out_valid)
				stop_with_failure("in_ready was high while a memory operation was in flight");
			if (out_valid)
				compare_completion();
		end
	end

	// memory model with random ready and valid stalls
	always @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < MEM_BEATS; i++)
				for (int k = 0; k < BEAT_BYTES; k++)
					mem[i][k*8 +: 8] = fill_byte(i * BEAT_BYTES + k);
			ar_ready <= 1'b0;
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
			r_valid <= 1'b0;
			b_valid <= 1'b0;
			rd_pending <= 1'b0;
			b_pending <= 1'b0;
		end else begin
			mem_rng = xorshift(mem_rng);
			ar_ready <= mem_rng[1:0] != 2'd0;
			aw_ready <= mem_rng[3:2] != 2'd0;
			w_ready <= mem_rng[5:4] != 2'd0;
			if (ar_valid && ar_ready) begin
				if (exp_ar_q.size() == 0)
					stop_with_failure("read address issued with no load expected");
				else
					check_addr("ar_addr", ar_addr, exp_ar_q.pop_front());
				rd_addr <= ar_addr;
				rd_pending <= 1'b1;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
			end else if (rd_pending && !r_valid && mem_rng[7:6] != 2'd0) begin
				r_valid <= 1'b1;
				r_data <= mem[rd_addr[8:3]];
				rd_pending <= 1'b0;
			end
			if (aw_valid && aw_ready) begin
				if (exp_aw_q.size() == 0)
					stop_with_failure("write address issued with no store expected");
				else
					check_addr("aw_addr", aw_addr, exp_aw_q.pop_front());
				wr_addr <= aw_addr;
			end
			if (w_valid && w_ready) begin
				if (exp_strb_q.size() == 0)
					stop_with_failure("write data beat issued with no store expected");
				else
					check_strb("w_strb", w_strb, exp_strb_q.pop_front());
				for (int k = 0; k < BEAT_BYTES; k++)
					if (w_strb[k])
						mem[wr_addr[8:3]][k*8 +: 8] = w_data[k*8 +: 8];
				b_pending <= 1'b1;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end else if (b_pending && !b_valid && mem_rng[9:8] != 2'd0) begin
				b_valid <= 1'b1;
				b_pending <= 1'b0;
			end
		end
	end

	// watchdog sized from the program length
	initial begin
		wait (num_ops != 0);
		repeat (num_ops * 64) @(posedge clock);
		stop_with_failure("timeout: operations did not all complete in the allowed cycles");
	end

endmodule

// File: build.f
hw/exu_pkg.sv
hw/mem_plan_if.sv
hw/exu_stage_ctrl.sv
hw/access_planner.sv
hw/load_engine.sv
hw/store_engine.sv
hw/load_aligner.sv
hw/exu_lsu_top.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_top -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
